/* Bender.yml */
package:
  name: lv_hv_shadow_reg

sources:
  # packages first, then the capture and bank, then the top level
  - files:
      - rtl/owt_pkg.sv
      - rtl/shadow_reg_pkg.sv
      - rtl/owt_rx_capture.sv
      - rtl/shadow_reg_bank.sv
      - rtl/lv_hv_shadow_reg.sv
  - target: test
    files:
      - bench/lv_hv_shadow_reg_assertions.sv
      - bench/tb_lv_hv_shadow_reg.sv

/* bench/lv_hv_shadow_reg_assertions.sv */
// bound into owt_rx_capture; assertions are disabled while reset is low, except the reset check
`timescale 1ns/10ps

module lv_hv_shadow_reg_assertions (
    input logic                         i_clk,
    input logic                         i_rst_n,
    input owt_pkg::owt_rx_frame_t       i_owt_rx,
    input shadow_reg_pkg::reg_wr_req_t  i_wr_req,
    input logic                         i_hv_reg_vld
);

    // ====================
    // frame qualification
    // ====================

    // strobe only for error-free writes
    a_wen_qualified: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_wr_req.wen |-> (!i_owt_rx.status &&
            (i_owt_rx.cmd[owt_pkg::OWT_CMD_BIT_NUM-1] == owt_pkg::OWT_OP_WRITE))
    ) else $error("write strobe raised for an erroneous frame or a read");

    // ====================
    // valid pulse timing
    // ====================

    a_vld_follows_ack: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_owt_rx.ack |=> i_hv_reg_vld
    ) else $error("valid pulse missing one cycle after ack");

    a_vld_low_without_ack: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        !i_owt_rx.ack |=> !i_hv_reg_vld
    ) else $error("valid pulse raised without a preceding ack");

    a_vld_low_in_reset: assert property (
        @(posedge i_clk)
        !i_rst_n |-> !i_hv_reg_vld
    ) else $error("valid pulse high while reset is held");

endmodule

bind owt_rx_capture lv_hv_shadow_reg_assertions lv_hv_shadow_reg_assertions_inst (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_owt_rx     (i_owt_rx),
    .i_wr_req     (o_wr_req),
    .i_hv_reg_vld (o_hv_reg_vld)
);

/* bench/tb_lv_hv_shadow_reg.sv */
// self-checking testbench; random frames from a fixed seed, stops at the first mismatch
`timescale 1ns/10ps

module tb_lv_hv_shadow_reg;

    localparam int CLK_HALF      = 4;
    localparam int RESET_CYCLES  = 4;
    localparam int RESET_TIMEOUT = 20;
    localparam int RAND_CYCLES   = 4000;

    logic                               i_clk;
    logic                               i_rst_n;
    owt_pkg::owt_rx_frame_t             i_owt_rx;
    shadow_reg_pkg::shadow_regs_t       o_regs;
    logic                               o_hv_reg_vld;
    logic [shadow_reg_pkg::REG_DW-1:0]  o_hv_ang_reg_data;

    // reference model state
    shadow_reg_pkg::shadow_regs_t       model_regs;
    logic                               model_vld;
    logic [shadow_reg_pkg::REG_DW-1:0]  model_ang;
    integer                             seed;

    lv_hv_shadow_reg lv_hv_shadow_reg_inst (
        .i_clk             (i_clk),
        .i_rst_n           (i_rst_n),
        .i_owt_rx          (i_owt_rx),
        .o_regs            (o_regs),
        .o_hv_reg_vld      (o_hv_reg_vld),
        .o_hv_ang_reg_data (o_hv_ang_reg_data)
    );

    initial begin
        i_clk = 1'b0;
        forever #CLK_HALF i_clk = ~i_clk;
    end

    // ====================
    // checking
    // ====================

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_regs(input shadow_reg_pkg::shadow_regs_t exp_regs,
                              input shadow_reg_pkg::shadow_regs_t act_regs);
        if (act_regs !== exp_regs) begin
            stop_with_error($sformatf("mismatch at %0t ns: o_regs expected %h, got %h",
                                      $time, exp_regs, act_regs));
        end
    endtask

    task automatic check_vld(input logic exp_vld, input logic act_vld);
        if (act_vld !== exp_vld) begin
            stop_with_error($sformatf("mismatch at %0t ns: o_hv_reg_vld expected %b, got %b",
                                      $time, exp_vld, act_vld));
        end
    endtask

    task automatic check_ang(input logic [shadow_reg_pkg::REG_DW-1:0] exp_ang,
                             input logic [shadow_reg_pkg::REG_DW-1:0] act_ang);
        if (act_ang !== exp_ang) begin
            stop_with_error($sformatf("mismatch at %0t ns: o_hv_ang_reg_data expected %h, got %h",
                                      $time, exp_ang, act_ang));
        end
    endtask

    // ====================
    // model and stimulus
    // ====================

    // register map as documented for the HV die
    function automatic shadow_reg_pkg::shadow_regs_t apply_frame(
        input shadow_reg_pkg::shadow_regs_t regs,
        input owt_pkg::owt_rx_frame_t frame
    );
        shadow_reg_pkg::shadow_regs_t nxt;
        nxt = regs;
        if (frame.ack && !frame.status && frame.cmd[7]) begin
            case (frame.cmd[6:0])
                7'h06: nxt.efuse_config = frame.data[7:0];
                7'h07: nxt.efuse_status = frame.data[7:0];
                7'h08: nxt.status1 = frame.data[7:0];
                7'h0A: nxt.status2 = frame.data[7:0];
                7'h0C: nxt.status3 = frame.data[7:0];
                7'h0D: nxt.status4 = frame.data[7:0];
                7'h14: nxt.bist1 = frame.data[7:0];
                7'h15: nxt.bist2 = frame.data[7:0];
                7'h1F: begin
                    nxt.adc1 = frame.data[9:0];
                    nxt.adc2 = frame.data[19:10];
                end
                default: nxt = regs;
            endcase
        end
        return nxt;
    endfunction

    function automatic logic [6:0] mapped_addr(input int idx);
        case (idx)
            0: return 7'h06;
            1: return 7'h07;
            2: return 7'h08;
            3: return 7'h0A;
            4: return 7'h0C;
            5: return 7'h0D;
            6: return 7'h14;
            7: return 7'h15;
            default: return 7'h1F;
        endcase
    endfunction

    function automatic owt_pkg::owt_rx_frame_t make_frame(input logic ack, input logic wr,
                                                          input logic [6:0] addr,
                                                          input logic [19:0] data,
                                                          input logic err);
        owt_pkg::owt_rx_frame_t frame;
        frame.ack    = ack;
        frame.cmd    = {wr, addr};
        frame.data   = data;
        frame.status = err;
        return frame;
    endfunction

    // mostly mapped addresses, error about one in eight, ack dropped one in four
    task automatic random_frame(output owt_pkg::owt_rx_frame_t frame);
        int          pick;
        logic [6:0]  addr;
        logic [31:0] rnd;
        pick = $unsigned($random(seed)) % 12;
        rnd  = $random(seed);
        addr = (pick < 10) ? mapped_addr(pick) : rnd[6:0];
        rnd  = $random(seed);
        frame = make_frame(rnd[1:0] != 2'b00, rnd[2], addr, rnd[31:12], rnd[5:3] == 3'b000);
    endtask

    // called 1 ns after an edge, returns 1 ns after the next one
    task automatic run_cycle(input owt_pkg::owt_rx_frame_t frame);
        i_owt_rx = frame;
        @(posedge i_clk);
        model_regs = apply_frame(model_regs, frame);
        model_vld  = frame.ack;
        model_ang  = frame.data[7:0];
        #1;
        check_regs(model_regs, o_regs);
        check_vld(model_vld, o_hv_reg_vld);
        check_ang(model_ang, o_hv_ang_reg_data);
    endtask

    // ====================
    // test sequence
    // ====================

    initial begin
        owt_pkg::owt_rx_frame_t frame;
        logic [31:0]            rnd;
        int                     wait_cnt;
        seed       = 32'h581a_3a63;
        i_rst_n    = 1'b0;
        i_owt_rx   = '0;
        model_regs = '0;
        model_vld  = 1'b0;
        model_ang  = '0;
        repeat (RESET_CYCLES) @(posedge i_clk);
        #1;
        // outputs cleared while reset is still held
        check_regs('0, o_regs);
        check_vld(1'b0, o_hv_reg_vld);
        check_ang('0, o_hv_ang_reg_data);
        i_rst_n  = 1'b1;
        wait_cnt = 0;
        while (!((o_regs === '0) && (o_hv_reg_vld === 1'b0) && (o_hv_ang_reg_data === '0))) begin
            if (wait_cnt == RESET_TIMEOUT) begin
                stop_with_error("timeout: outputs did not settle to zero after reset");
            end
            @(posedge i_clk);
            #1;
            wait_cnt++;
        end

        // one clean write per mapped address
        for (int i = 0; i < 10; i++) begin
            rnd = $random(seed);
            run_cycle(make_frame(1'b1, 1'b1, mapped_addr(i), rnd[19:0], 1'b0));
        end

        // rejected frames: error, read, no ack, unmapped
        rnd = $random(seed);
        run_cycle(make_frame(1'b1, 1'b1, 7'h06, rnd[19:0], 1'b1));
        run_cycle(make_frame(1'b1, 1'b0, 7'h08, ~rnd[19:0], 1'b0));
        run_cycle(make_frame(1'b0, 1'b1, 7'h14, rnd[31:12], 1'b0));
        run_cycle(make_frame(1'b1, 1'b1, 7'h00, rnd[19:0], 1'b0));
        run_cycle(make_frame(1'b1, 1'b1, 7'h1E, ~rnd[31:12], 1'b0));
        run_cycle('0);

        repeat (RAND_CYCLES) begin
            random_frame(frame);
            run_cycle(frame);
        end

        $display("Done: no errors");
        $finish;
    end

endmodule

/* lv_hv_shadow_reg.f */
rtl/owt_pkg.sv
rtl/shadow_reg_pkg.sv
rtl/owt_rx_capture.sv
rtl/shadow_reg_bank.sv
rtl/lv_hv_shadow_reg.sv
bench/lv_hv_shadow_reg_assertions.sv
bench/tb_lv_hv_shadow_reg.sv

/* rtl/lv_hv_shadow_reg.sv */
// top level of the LV shadow copy; frames consumed on arrival, no back-pressure toward the link
`timescale 1ns/10ps

module lv_hv_shadow_reg (
    input  logic                                i_clk,
    input  logic                                i_rst_n,
    input  owt_pkg::owt_rx_frame_t              i_owt_rx,
    output shadow_reg_pkg::shadow_regs_t        o_regs,
    output logic                                o_hv_reg_vld,
    output logic [shadow_reg_pkg::REG_DW-1:0]   o_hv_ang_reg_data
);

    shadow_reg_pkg::reg_wr_req_t w_wr_req;

    // ====================
    // frame capture
    // ====================

    owt_rx_capture owt_rx_capture_inst (
        .i_clk             (i_clk),
        .i_rst_n           (i_rst_n),
        .i_owt_rx          (i_owt_rx),
        .o_wr_req          (w_wr_req),
        .o_hv_reg_vld      (o_hv_reg_vld),
        .o_hv_ang_reg_data (o_hv_ang_reg_data)
    );

    // ====================
    // register bank
    // ====================

    shadow_reg_bank shadow_reg_bank_inst (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_wr_req (w_wr_req),
        .o_regs   (o_regs)
    );

endmodule

/* rtl/owt_pkg.sv */
// one-wire link frame format; widths fixed by the transport receiver, cmd MSB is the opcode
package owt_pkg;

    // ====================
    // link widths
    // ====================

    // opcode bit plus 7-bit register address
    localparam int OWT_CMD_BIT_NUM  = 8;
    // two packed ADC samples
    localparam int OWT_ADCD_BIT_NUM = 20;

    // ====================
    // command opcode
    // ====================

    // carried in cmd[OWT_CMD_BIT_NUM-1]
    typedef enum logic {
        OWT_OP_READ  = 1'b0,
        OWT_OP_WRITE = 1'b1
    } owt_op_e;

    // ====================
    // received frame
    // ====================

    // ack is a single-cycle pulse per frame
    // status 1 means the receiver flagged an error
    typedef struct packed {
        logic                        ack;
        logic [OWT_CMD_BIT_NUM-1:0]  cmd;
        logic [OWT_ADCD_BIT_NUM-1:0] data;
        logic                        status;
    } owt_rx_frame_t;

endpackage

/* rtl/owt_rx_capture.sv */
// write request is combinational from the frame; valid and angle lag the frame by one cycle
`timescale 1ns/10ps

module owt_rx_capture (
    input  logic                                i_clk,
    input  logic                                i_rst_n,
    input  owt_pkg::owt_rx_frame_t              i_owt_rx,
    output shadow_reg_pkg::reg_wr_req_t         o_wr_req,
    output logic                                o_hv_reg_vld,
    output logic [shadow_reg_pkg::REG_DW-1:0]   o_hv_ang_reg_data
);

    owt_pkg::owt_op_e rx_op;

    // ====================
    // frame qualification
    // ====================

    assign rx_op = owt_pkg::owt_op_e'(i_owt_rx.cmd[owt_pkg::OWT_CMD_BIT_NUM-1]);

    // erroneous frames and reads never reach the bank
    assign o_wr_req.wen   = i_owt_rx.ack & ~i_owt_rx.status & (rx_op == owt_pkg::OWT_OP_WRITE);
    assign o_wr_req.addr  = i_owt_rx.cmd[shadow_reg_pkg::REG_AW-1:0];
    assign o_wr_req.wdata = i_owt_rx.data;

    // ====================
    // delayed outputs
    // ====================

    // pulses for every acked frame, rejected ones too
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_hv_reg_vld <= 1'b0;
        end else begin
            o_hv_reg_vld <= i_owt_rx.ack;
        end
    end

    // sampled every cycle regardless of ack
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_hv_ang_reg_data <= '0;
        end else begin
            o_hv_ang_reg_data <= i_owt_rx.data[shadow_reg_pkg::REG_DW-1:0];
        end
    end

endmodule

/* rtl/shadow_reg_bank.sv */
// unmapped addresses are ignored silently; ADC address loads both samples from one frame
`timescale 1ns/10ps

module shadow_reg_bank (
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    input  shadow_reg_pkg::reg_wr_req_t     i_wr_req,
    output shadow_reg_pkg::shadow_regs_t    o_regs
);

    shadow_reg_pkg::shadow_addr_e   wr_addr;
    shadow_reg_pkg::shadow_regs_t   regs_d;
    shadow_reg_pkg::shadow_regs_t   regs_q;
    logic [shadow_reg_pkg::REG_DW-1:0] wr_byte;
    logic [shadow_reg_pkg::ADC_DW-1:0] wr_adc_lo;
    logic [shadow_reg_pkg::ADC_DW-1:0] wr_adc_hi;

    assign wr_addr = shadow_reg_pkg::shadow_addr_e'(i_wr_req.addr);

    // ====================
    // data slices
    // ====================

    assign wr_byte   = i_wr_req.wdata[shadow_reg_pkg::REG_DW-1:0];
    assign wr_adc_lo = i_wr_req.wdata[shadow_reg_pkg::ADC_DW-1:0];
    // ADC2 sits in the upper half of the data word
    assign wr_adc_hi = i_wr_req.wdata[2*shadow_reg_pkg::ADC_DW-1 -: shadow_reg_pkg::ADC_DW];

    // ====================
    // address decode
    // ====================

    always_comb begin
        regs_d = regs_q;
        if (i_wr_req.wen) begin
            case (wr_addr)
                shadow_reg_pkg::ADDR_EFUSE_CONFIG: begin
                    regs_d.efuse_config = wr_byte;
                end
                shadow_reg_pkg::ADDR_EFUSE_STATUS: begin
                    regs_d.efuse_status = wr_byte;
                end
                shadow_reg_pkg::ADDR_STATUS1: begin
                    regs_d.status1 = wr_byte;
                end
                shadow_reg_pkg::ADDR_STATUS2: begin
                    regs_d.status2 = wr_byte;
                end
                shadow_reg_pkg::ADDR_STATUS3: begin
                    regs_d.status3 = wr_byte;
                end
                shadow_reg_pkg::ADDR_STATUS4: begin
                    regs_d.status4 = wr_byte;
                end
                shadow_reg_pkg::ADDR_BIST1: begin
                    regs_d.bist1 = wr_byte;
                end
                shadow_reg_pkg::ADDR_BIST2: begin
                    regs_d.bist2 = wr_byte;
                end
                shadow_reg_pkg::ADDR_ADC_DATA: begin
                    // both samples in the same cycle
                    regs_d.adc1 = wr_adc_lo;
                    regs_d.adc2 = wr_adc_hi;
                end
                default: begin
                    // unmapped, hold everything
                end
            endcase
        end
    end

    // ====================
    // shadow storage
    // ====================

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            regs_q <= '0;
        end else begin
            regs_q <= regs_d;
        end
    end

    assign o_regs = regs_q;

endmodule

/* rtl/shadow_reg_pkg.sv */
// register map of the HV die shadow copy; all shadows reset to zero, no read path
package shadow_reg_pkg;

    // ====================
    // map widths
    // ====================

    localparam int REG_AW = 7;
    localparam int REG_DW = 8;
    // one ADC sample, two per data word
    localparam int ADC_DW = 10;

    // ====================
    // mapped addresses
    // ====================

    typedef enum logic [REG_AW-1:0] {
        ADDR_EFUSE_CONFIG = 7'h06,
        ADDR_EFUSE_STATUS = 7'h07,
        ADDR_STATUS1      = 7'h08,
        ADDR_STATUS2      = 7'h0A,
        ADDR_STATUS3      = 7'h0C,
        ADDR_STATUS4      = 7'h0D,
        ADDR_BIST1        = 7'h14,
        ADDR_BIST2        = 7'h15,
        // loads both ADC shadows at once
        ADDR_ADC_DATA     = 7'h1F
    } shadow_addr_e;

    // ====================
    // write request
    // ====================

    // wen is already qualified by ack, status and opcode
    // address is not checked yet
    typedef struct packed {
        logic                  wen;
        logic [REG_AW-1:0]     addr;
        logic [2*ADC_DW-1:0]   wdata;
    } reg_wr_req_t;

    // ====================
    // shadow registers
    // ====================

    typedef struct packed {
        logic [REG_DW-1:0] efuse_config;
        logic [REG_DW-1:0] efuse_status;
        logic [REG_DW-1:0] status1;
        logic [REG_DW-1:0] status2;
        logic [REG_DW-1:0] status3;
        logic [REG_DW-1:0] status4;
        logic [REG_DW-1:0] bist1;
        logic [REG_DW-1:0] bist2;
        logic [ADC_DW-1:0] adc1;
        logic [ADC_DW-1:0] adc2;
    } shadow_regs_t;

endpackage
